/* Bender.yml */
package:
  name: polar_alu

sources:
  - alu_pkg.sv
  - int_arith_unit.sv
  - alu_shifter.sv
  - polar_simd_unit.sv
  - alu_result_stage.sv
  - polar_alu_top.sv
  - target: simulation
    files:
      - tb_polar_alu.sv

/* all.f */
alu_pkg.sv
int_arith_unit.sv
alu_shifter.sv
polar_simd_unit.sv
alu_result_stage.sv
polar_alu_top.sv
tb_polar_alu.sv

/* alu_pkg.sv */
// Shared widths, vector types and operator encoding of the polar SIMD ALU.
// Import into a module body with a wildcard import; use scoped names in port lists.
`default_nettype none

package alu_pkg;

    // --------------------
    // Widths
    // --------------------
    localparam int XLEN      = 64;
    localparam int WORD_W    = 32;
    localparam int LANE_W    = 8;
    localparam int NUM_LANES = 4;
    // Symmetric clamp for lane add/sub
    localparam int SAT_MAX   = 127;

    typedef logic [XLEN-1:0]   xlen_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [LANE_W-1:0] lane_t;
    typedef logic [5:0]        shamt_t;

    // --------------------
    // Operators
    // --------------------
    typedef enum logic [5:0] {
        ADD, SUB, ADDW, SUBW,
        ANDL, ORL, XORL, ANDN, ORN, XNOR,
        SLL, SRL, SRA, SLLW, SRLW, SRAW,
        SLTS, SLTU,
        EQ, NE, LTS, LTU, GES, GEU,
        PL_ADDSAT, PL_SUBSAT, PL_F, PL_R, PL_EVAL,
        PL_VREPSUM, PL_VADDREP1, PL_VADDREP2
    } alu_op_e;

    typedef enum logic [1:0] {
        UNIT_ARITH,
        UNIT_SHIFT,
        UNIT_POLAR
    } unit_e;

    // Which functional unit produces the result of an operator
    function automatic unit_e op_unit(input alu_op_e op);
        unit_e unit;
        unit = UNIT_ARITH;
        case (op)
            SLL, SRL, SRA,
            SLLW, SRLW, SRAW: unit = UNIT_SHIFT;
            PL_ADDSAT, PL_SUBSAT, PL_F, PL_R, PL_EVAL,
            PL_VREPSUM, PL_VADDREP1, PL_VADDREP2: unit = UNIT_POLAR;
            // compares and branches stay on the adder
            default: unit = UNIT_ARITH;
        endcase
        return unit;
    endfunction

endpackage

`default_nettype wire

/* alu_result_stage.sv */
// Output stage of the ALU pipeline.
// Picks the unit result for the operator and registers it with the branch flag.
`timescale 1ns/10ps
`default_nettype none

module alu_result_stage (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   arith_result_i,
    input  alu_pkg::xlen_t   shift_result_i,
    input  alu_pkg::xlen_t   polar_result_i,
    input  logic             branch_taken_i,
    output alu_pkg::xlen_t   result_o,
    output logic             branch_o,
    output logic             valid_o
);
    import alu_pkg::*;

    xlen_t result_sel;

    // --------------------
    // Unit select
    // --------------------
    always_comb begin
        case (op_unit(op_i))
            UNIT_SHIFT: result_sel = shift_result_i;
            UNIT_POLAR: result_sel = polar_result_i;
            default:    result_sel = arith_result_i;
        endcase
    end

    // --------------------
    // Output register
    // --------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            result_o <= '0;
            branch_o <= 1'b0;
            valid_o  <= 1'b0;
        end else begin
            valid_o <= valid_i;
            // Idle cycles hold the last result
            if (valid_i) begin
                result_o <= result_sel;
                branch_o <= branch_taken_i;
            end
        end
    end

endmodule

`default_nettype wire

/* alu_shifter.sv */
// Combinational shifter for SLL/SRL/SRA and their word forms.
// Left shifts run through the right shifter on bit-reversed data.
`timescale 1ns/10ps
`default_nettype none

module alu_shifter (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   shift_result_o
);
    import alu_pkg::*;

    logic            shift_left;
    logic            shift_arith;
    logic            word_op;
    shamt_t          shamt;
    xlen_t           operand_a_rev;
    xlen_t           shift_in;
    xlen_t           shift_left_res;
    logic [XLEN:0]   shift_right_res;
    word_t           operand_a_rev32;
    word_t           shift_in32;
    word_t           shift_left_res32;
    word_t           word_result;
    logic [WORD_W:0] shift_right_res32;

    assign shift_left  = (op_i == SLL) || (op_i == SLLW);
    assign shift_arith = (op_i == SRA) || (op_i == SRAW);
    assign word_op     = (op_i == SLLW) || (op_i == SRLW) || (op_i == SRAW);
    assign shamt       = operand_b_i[5:0];

    // Bit reversal before and after the shifter
    for (genvar k = 0; k < XLEN; k++) begin : g_rev64
        assign operand_a_rev[k]  = operand_a_i[XLEN-1-k];
        assign shift_left_res[k] = shift_right_res[XLEN-1-k];
    end

    for (genvar k = 0; k < WORD_W; k++) begin : g_rev32
        assign operand_a_rev32[k]  = operand_a_i[WORD_W-1-k];
        assign shift_left_res32[k] = shift_right_res32[WORD_W-1-k];
    end

    assign shift_in   = shift_left ? operand_a_rev : operand_a_i;
    assign shift_in32 = shift_left ? operand_a_rev32 : operand_a_i[WORD_W-1:0];

    // Extra top bit carries the fill value
    assign shift_right_res = $unsigned($signed({shift_arith & shift_in[XLEN-1], shift_in})
                                       >>> shamt);
    assign shift_right_res32 = $unsigned($signed({shift_arith & shift_in32[WORD_W-1], shift_in32})
                                         >>> shamt[4:0]);

    assign word_result = shift_left ? shift_left_res32 : shift_right_res32[WORD_W-1:0];

    assign shift_result_o = word_op ?
        {{(XLEN-WORD_W){word_result[WORD_W-1]}}, word_result} :
        (shift_left ? shift_left_res : shift_right_res[XLEN-1:0]);

endmodule

`default_nettype wire

/* int_arith_unit.sv */
// Combinational adder, logic, compare and branch unit.
// Logic ops share the adder's inverted operand b.
`timescale 1ns/10ps
`default_nettype none

module int_arith_unit (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   arith_result_o,
    output logic             branch_taken_o
);
    import alu_pkg::*;

    logic          negate_b;
    logic          signed_cmp;
    logic          less;
    logic          zero_flag;
    logic [XLEN:0] adder_in_a;
    logic [XLEN:0] operand_b_neg;
    logic [XLEN:0] adder_sum;
    xlen_t         adder_result;
    xlen_t         logic_b;
    word_t         word_sum;

    // --------------------
    // Adder
    // --------------------
    always_comb begin
        case (op_i)
            SUB, SUBW, EQ, NE, ANDN, ORN, XNOR: negate_b = 1'b1;
            default: negate_b = 1'b0;
        endcase
    end

    // Appended low bit turns the inversion into a two's complement
    assign adder_in_a    = {operand_a_i, 1'b1};
    assign operand_b_neg = {operand_b_i, 1'b0} ^ {(XLEN+1){negate_b}};
    assign adder_sum     = adder_in_a + operand_b_neg;
    assign adder_result  = adder_sum[XLEN:1];
    assign word_sum      = adder_result[WORD_W-1:0];
    assign logic_b       = operand_b_neg[XLEN:1];
    assign zero_flag     = ~|adder_result;

    // --------------------
    // Compare
    // --------------------
    assign signed_cmp = (op_i == SLTS) || (op_i == LTS) || (op_i == GES);
    assign less = $signed({signed_cmp & operand_a_i[XLEN-1], operand_a_i}) <
                  $signed({signed_cmp & operand_b_i[XLEN-1], operand_b_i});

    always_comb begin
        case (op_i)
            EQ:       branch_taken_o = zero_flag;
            NE:       branch_taken_o = ~zero_flag;
            LTS, LTU: branch_taken_o = less;
            GES, GEU: branch_taken_o = ~less;
            default:  branch_taken_o = 1'b1;
        endcase
    end

    // Branch operators give a zero result
    always_comb begin
        case (op_i)
            ADD, SUB:   arith_result_o = adder_result;
            ADDW, SUBW: arith_result_o = {{(XLEN-WORD_W){word_sum[WORD_W-1]}}, word_sum};
            ANDL, ANDN: arith_result_o = operand_a_i & logic_b;
            ORL, ORN:   arith_result_o = operand_a_i | logic_b;
            XORL, XNOR: arith_result_o = operand_a_i ^ logic_b;
            SLTS, SLTU: arith_result_o = {{(XLEN-1){1'b0}}, less};
            default:    arith_result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* polar_alu_top.sv */
// Top of the single-stage polar SIMD ALU.
// One operation per cycle on valid_i, result one cycle later with valid_o.
`timescale 1ns/10ps
`default_nettype none

module polar_alu_top (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             valid_i,
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output logic             valid_o,
    output alu_pkg::xlen_t   result_o,
    output logic             branch_o
);
    import alu_pkg::*;

    xlen_t arith_result;
    xlen_t shift_result;
    xlen_t polar_result;
    logic  branch_taken;

    // Functional units in parallel
    int_arith_unit i_int_arith_unit (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .arith_result_o (arith_result),
        .branch_taken_o (branch_taken)
    );

    alu_shifter i_alu_shifter (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .shift_result_o (shift_result)
    );

    polar_simd_unit i_polar_simd_unit (
        .op_i           (op_i),
        .operand_a_i    (operand_a_i),
        .operand_b_i    (operand_b_i),
        .polar_result_o (polar_result)
    );

    alu_result_stage i_alu_result_stage (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .valid_i        (valid_i),
        .op_i           (op_i),
        .arith_result_i (arith_result),
        .shift_result_i (shift_result),
        .polar_result_i (polar_result),
        .branch_taken_i (branch_taken),
        .result_o       (result_o),
        .branch_o       (branch_o),
        .valid_o        (valid_o)
    );

endmodule

`default_nettype wire

/* polar_simd_unit.sv */
// Four-lane signed 8-bit operations for polar code decoding.
// Works on bits 31:0 of both operands; result bits 63:32 are zero.
`timescale 1ns/10ps
`default_nettype none

module polar_simd_unit (
    input  alu_pkg::alu_op_e op_i,
    input  alu_pkg::xlen_t   operand_a_i,
    input  alu_pkg::xlen_t   operand_b_i,
    output alu_pkg::xlen_t   polar_result_o
);
    import alu_pkg::*;

    word_t addsat_v;
    word_t subsat_v;
    word_t f_v;
    word_t r_v;
    word_t eval_v;
    word_t repsum_v;
    word_t addrep1_v;
    word_t addrep2_v;
    word_t polar_word;
    logic  r_block;

    // Clamp a 9-bit signed value into +/- SAT_MAX
    function automatic lane_t sat_lane(input logic signed [LANE_W:0] value);
        lane_t res;
        if (value > SAT_MAX) begin
            res = lane_t'(SAT_MAX);
        end else if (value < -SAT_MAX) begin
            res = lane_t'(-SAT_MAX);
        end else begin
            res = value[LANE_W-1:0];
        end
        return res;
    endfunction

    // Half-word plus sign-extended byte modulo 2^16
    function automatic logic [2*LANE_W-1:0] add_rep(input logic [2*LANE_W-1:0] half,
                                                    input lane_t byte_v);
        return half + {{LANE_W{byte_v[LANE_W-1]}}, byte_v};
    endfunction

    // --------------------
    // Per-lane ops
    // --------------------
    assign r_block = (operand_b_i[LANE_W-1:0] == lane_t'(1));

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_t                  a_lane;
        lane_t                  b_lane;
        lane_t                  abs_a;
        lane_t                  abs_b;
        lane_t                  min_mag;
        logic signed [LANE_W:0] lane_sum;
        logic signed [LANE_W:0] lane_diff;

        assign a_lane = operand_a_i[i*LANE_W +: LANE_W];
        assign b_lane = operand_b_i[i*LANE_W +: LANE_W];

        assign lane_sum  = $signed(a_lane) + $signed(b_lane);
        assign lane_diff = $signed(a_lane) - $signed(b_lane);
        assign addsat_v[i*LANE_W +: LANE_W] = sat_lane(lane_sum);
        assign subsat_v[i*LANE_W +: LANE_W] = sat_lane(lane_diff);

        // Min-sum f keeps magnitude 0x80 for a 0x80 lane
        assign abs_a   = a_lane[LANE_W-1] ? -a_lane : a_lane;
        assign abs_b   = b_lane[LANE_W-1] ? -b_lane : b_lane;
        assign min_mag = (abs_b < abs_a) ? abs_b : abs_a;
        assign f_v[i*LANE_W +: LANE_W] =
            (a_lane[LANE_W-1] ^ b_lane[LANE_W-1]) ? -min_mag : min_mag;

        assign r_v[i*LANE_W +: LANE_W] =
            r_block ? '0 : lane_t'(a_lane[LANE_W-1]);
        assign eval_v[i*LANE_W +: LANE_W] = (a_lane == lane_t'(1)) ? '1 : '0;
    end

    // --------------------
    // Repacking
    // --------------------
    assign repsum_v = {lane_t'(operand_b_i[31]), lane_t'(operand_b_i[15]),
                       lane_t'(operand_a_i[31]), lane_t'(operand_a_i[15])};

    assign addrep1_v = {add_rep(operand_a_i[31:16], operand_b_i[15:8]),
                        add_rep(operand_a_i[15:0], operand_b_i[7:0])};
    assign addrep2_v = {add_rep(operand_a_i[31:16], operand_b_i[31:24]),
                        add_rep(operand_a_i[15:0], operand_b_i[23:16])};

    always_comb begin
        case (op_i)
            PL_ADDSAT:   polar_word = addsat_v;
            PL_SUBSAT:   polar_word = subsat_v;
            PL_F:        polar_word = f_v;
            PL_R:        polar_word = r_v;
            PL_EVAL:     polar_word = eval_v;
            PL_VREPSUM:  polar_word = repsum_v;
            PL_VADDREP1: polar_word = addrep1_v;
            PL_VADDREP2: polar_word = addrep2_v;
            default:     polar_word = '0;
        endcase
    end

    assign polar_result_o = {{(XLEN-WORD_W){1'b0}}, polar_word};

endmodule

`default_nettype wire

/* tb_polar_alu.sv */
// Self-checking testbench for the polar SIMD ALU.
// Applies a fixed table and random vectors, checks each result one cycle after issue.
`timescale 1ns/10ps
`default_nettype none

module tb_polar_alu;
    import alu_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int RANDOM_ROWS = 40;

    logic    clk_i;
    logic    rst_n_i;
    logic    valid_i;
    alu_op_e op_i;
    xlen_t   operand_a_i;
    xlen_t   operand_b_i;
    logic    valid_o;
    logic    branch_o;
    xlen_t   result_o;

    alu_op_e row_op[$];
    xlen_t   row_a[$];
    xlen_t   row_b[$];
    xlen_t   row_res[$];
    logic    row_br[$];
    int      seed = 17575;
    int      pass_count = 0;
    int      fail_count = 0;
    bit      rows_ready = 1'b0;

    polar_alu_top UUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .valid_i     (valid_i),
        .op_i        (op_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .branch_o    (branch_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // Reference model returning {branch, result}
    // --------------------
    function automatic logic [XLEN:0] model_result(input alu_op_e op, input xlen_t a,
                                                   input xlen_t b);
        xlen_t r;
        logic  br;
        word_t w;
        lane_t la;
        lane_t lb;
        lane_t ma;
        lane_t mb;
        lane_t m;
        int    s;
        r  = '0;
        br = 1'b1;
        case (op)
            ADD:  r = a + b;
            SUB:  r = a - b;
            ADDW: begin
                w = a[31:0] + b[31:0];
                r = {{32{w[31]}}, w};
            end
            SUBW: begin
                w = a[31:0] - b[31:0];
                r = {{32{w[31]}}, w};
            end
            ANDL: r = a & b;
            ORL:  r = a | b;
            XORL: r = a ^ b;
            ANDN: r = a & ~b;
            ORN:  r = a | ~b;
            XNOR: r = a ^ ~b;
            SLL:  r = a << b[5:0];
            SRL:  r = a >> b[5:0];
            SRA:  r = $signed(a) >>> b[5:0];
            SLLW, SRLW, SRAW: begin
                if (op == SLLW) w = a[31:0] << b[4:0];
                else if (op == SRLW) w = a[31:0] >> b[4:0];
                else w = $signed(a[31:0]) >>> b[4:0];
                r = {{32{w[31]}}, w};
            end
            SLTS: r = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU: r = (a < b) ? 64'd1 : 64'd0;
            EQ:   br = (a == b);
            NE:   br = (a != b);
            LTS:  br = ($signed(a) < $signed(b));
            LTU:  br = (a < b);
            GES:  br = ($signed(a) >= $signed(b));
            GEU:  br = (a >= b);
            PL_VREPSUM: r = {32'h0, 7'h0, b[31], 7'h0, b[15], 7'h0, a[31], 7'h0, a[15]};
            PL_VADDREP1: r = {32'h0, a[31:16] + {{8{b[15]}}, b[15:8]},
                              a[15:0] + {{8{b[7]}}, b[7:0]}};
            PL_VADDREP2: r = {32'h0, a[31:16] + {{8{b[31]}}, b[31:24]},
                              a[15:0] + {{8{b[23]}}, b[23:16]}};
            default: begin
                // Lane ops on bytes of the low word
                for (int i = 0; i < NUM_LANES; i++) begin
                    la = a[8*i +: 8];
                    lb = b[8*i +: 8];
                    ma = la[7] ? (~la + 8'd1) : la;
                    mb = lb[7] ? (~lb + 8'd1) : lb;
                    m  = (mb < ma) ? mb : ma;
                    s  = (op == PL_ADDSAT) ? $signed(la) + $signed(lb)
                                           : $signed(la) - $signed(lb);
                    if (s > SAT_MAX) s = SAT_MAX;
                    if (s < -SAT_MAX) s = -SAT_MAX;
                    if (op == PL_ADDSAT || op == PL_SUBSAT) r[8*i +: 8] = s[7:0];
                    else if (op == PL_F) r[8*i +: 8] = (la[7] ^ lb[7]) ? ~m + 8'd1 : m;
                    else if (op == PL_R) r[8*i +: 8] = (b[7:0] == 8'h01) ? 8'h00 : la[7];
                    else r[8*i +: 8] = (la == 8'h01) ? 8'hff : 8'h00;
                end
            end
        endcase
        return {br, r};
    endfunction

    task automatic add_row(input alu_op_e op, input xlen_t a, input xlen_t b,
                           input xlen_t res, input logic br);
        row_op.push_back(op);
        row_a.push_back(a);
        row_b.push_back(b);
        row_res.push_back(res);
        row_br.push_back(br);
    endtask

    task automatic record_test(input string name, input logic ok);
        if (ok) pass_count++;
        else fail_count++;
        $display("test %s: %s", name, ok ? "pass" : "fail");
    endtask

    task automatic check_row(input int idx);
        logic ok;
        ok = 1'b1;
        assert (valid_o === 1'b1) else begin
            $display("test %0d: valid_o was not high one cycle after issue", idx);
            ok = 1'b0;
        end
        assert (result_o === row_res[idx]) else begin
            $display("error: test %0d result_o expected %h got %h", idx, row_res[idx], result_o);
            ok = 1'b0;
        end
        assert (branch_o === row_br[idx]) else begin
            $display("error: test %0d branch_o expected %h got %h", idx, row_br[idx], branch_o);
            ok = 1'b0;
        end
        record_test($sformatf("%0d %s", idx, row_op[idx].name()), ok);
    endtask

    // --------------------
    // Stimulus
    // --------------------
    initial begin
        logic [XLEN:0] expected;
        logic [31:0]   rnd;
        alu_op_e       op;
        xlen_t         a;
        xlen_t         b;
        logic          ok;
        rst_n_i     = 1'b0;
        valid_i     = 1'b0;
        op_i        = ADD;
        operand_a_i = '0;
        operand_b_i = '0;

        add_row(ADD, 64'hffffffffffffffff, 64'h1, 64'h0, 1'b1);
        add_row(SUB, 64'h0, 64'h1, 64'hffffffffffffffff, 1'b1);
        add_row(ADDW, 64'h7fffffff, 64'h1, 64'hffffffff80000000, 1'b1);
        add_row(SUBW, 64'h100000000, 64'h1, 64'hffffffffffffffff, 1'b1);
        add_row(ANDL, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf000f000f000f000, 1'b1);
        add_row(ORL, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hfff0fff0fff0fff0, 1'b1);
        add_row(XORL, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h0ff00ff00ff00ff0, 1'b1);
        add_row(XNOR, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf00ff00ff00ff00f, 1'b1);
        add_row(ANDN, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'h00f000f000f000f0, 1'b1);
        add_row(ORN, 64'hf0f0f0f0f0f0f0f0, 64'hff00ff00ff00ff00, 64'hf0fff0fff0fff0ff, 1'b1);
        add_row(SRA, 64'h8000000000000000, 64'h3f, 64'hffffffffffffffff, 1'b1);
        add_row(SRL, 64'h8000000000000000, 64'h3c, 64'h8, 1'b1);
        add_row(SLL, 64'h1, 64'h41, 64'h2, 1'b1);
        add_row(SRAW, 64'h80000000, 64'h4, 64'hfffffffff8000000, 1'b1);
        add_row(SRLW, 64'hffffffff80000000, 64'h24, 64'h08000000, 1'b1);
        add_row(SLLW, 64'h1, 64'h1f, 64'hffffffff80000000, 1'b1);
        add_row(SLTS, 64'hffffffffffffffff, 64'h1, 64'h1, 1'b1);
        add_row(SLTU, 64'hffffffffffffffff, 64'h1, 64'h0, 1'b1);
        add_row(EQ, 64'h5, 64'h5, 64'h0, 1'b1);
        add_row(EQ, 64'h8000000000000000, 64'h0, 64'h0, 1'b0);
        add_row(NE, 64'h5, 64'h5, 64'h0, 1'b0);
        add_row(LTS, 64'hffffffffffffffff, 64'h1, 64'h0, 1'b1);
        add_row(LTS, 64'h1, 64'hffffffffffffffff, 64'h0, 1'b0);
        add_row(LTU, 64'hffffffffffffffff, 64'h1, 64'h0, 1'b0);
        add_row(GES, 64'h5, 64'h5, 64'h0, 1'b1);
        add_row(GES, 64'hffffffffffffffff, 64'h1, 64'h0, 1'b0);
        add_row(GEU, 64'h0, 64'hffffffffffffffff, 64'h0, 1'b0);
        add_row(PL_ADDSAT, 64'hffffffff7f800102, 64'h01ff0304, 64'h7f810406, 1'b1);
        add_row(PL_SUBSAT, 64'h80007f10, 64'h01018120, 64'h81ff7ff0, 1'b1);
        add_row(PL_F, 64'h80fd0580, 64'h0103fb80, 64'hfffdfb80, 1'b1);
        add_row(PL_R, 64'h807fff00, 64'h2, 64'h01000100, 1'b1);
        add_row(PL_R, 64'h807fff00, 64'h1, 64'h0, 1'b1);
        add_row(PL_EVAL, 64'h0101ff02, 64'h0, 64'hffff0000, 1'b1);
        add_row(PL_VREPSUM, 64'h80007fff, 64'h00018000, 64'h00010100, 1'b1);
        add_row(PL_VADDREP1, 64'h00100020, 64'h8005, 64'hff900025, 1'b1);
        add_row(PL_VADDREP2, 64'h00100020, 64'h7f050000, 64'h008f0025, 1'b1);

        for (int k = 0; k < RANDOM_ROWS; k++) begin
            rnd      = $random(seed);
            op       = alu_op_e'({1'b0, rnd[4:0]});
            a        = {$random(seed), $random(seed)};
            b        = {$random(seed), $random(seed)};
            expected = model_result(op, a, b);
            add_row(op, a, b, expected[XLEN-1:0], expected[XLEN]);
        end
        rows_ready = 1'b1;

        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        ok = 1'b1;
        assert (valid_o === 1'b0 && result_o === '0 && branch_o === 1'b0) else begin
            $display("error: reset valid_o %h result_o %h branch_o %h", valid_o, result_o,
                     branch_o);
            ok = 1'b0;
        end
        record_test("reset", ok);

        // Issue one row per cycle and check the previous one
        for (int j = 0; j <= row_op.size(); j++) begin
            @(posedge clk_i);
            if (j < row_op.size()) begin
                valid_i     <= 1'b1;
                op_i        <= row_op[j];
                operand_a_i <= row_a[j];
                operand_b_i <= row_b[j];
            end else begin
                valid_i     <= 1'b0;
                op_i        <= ADD;
                operand_a_i <= '1;
            end
            @(negedge clk_i);
            if (j > 0) check_row(j - 1);
        end

        @(posedge clk_i);
        @(negedge clk_i);
        ok = 1'b1;
        assert (valid_o === 1'b0) else begin
            $display("valid_o stayed high after an idle cycle");
            ok = 1'b0;
        end
        assert (result_o === row_res[row_res.size() - 1]) else begin
            $display("error: idle result_o expected %h got %h", row_res[row_res.size() - 1],
                     result_o);
            ok = 1'b0;
        end
        record_test("idle hold", ok);

        $display("%0d tests passed, %0d tests with errors", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the number of rows
    initial begin
        wait (rows_ready);
        #((row_op.size() + 10) * CLK_PERIOD);
        $display("watchdog expired before all tests finished");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
